/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mem_unit
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir obj_dir
PASS_TEXT  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf obj_dir

/* design/load_align.sv */
module load_align import lsu_pkg::*; (
    ls_op_if.load_side op
);

    dword_u      rd;
    logic [7:0]  byte_f;
    logic [15:0] half_f;
    logic [31:0] word_f;

    assign rd.dw = op.read_data;

    // pick the addressed field, ignoring offset bits below the access size
    assign byte_f = rd.b[op.offset];
    assign half_f = rd.h[op.offset[2:1]];
    assign word_f = rd.w[op.offset[2]];

    always_comb begin
        unique case (op.size)
            size_b: begin
                if (op.is_unsigned) begin
                    op.ld_result = {56'b0, byte_f};
                end else begin
                    op.ld_result = {{56{byte_f[7]}}, byte_f};
                end
            end
            size_h: begin
                if (op.is_unsigned) begin
                    op.ld_result = {48'b0, half_f};
                end else begin
                    op.ld_result = {{48{half_f[15]}}, half_f};
                end
            end
            size_w: begin
                if (op.is_unsigned) begin // lwu
                    op.ld_result = {32'b0, word_f};
                end else begin
                    op.ld_result = {{32{word_f[31]}}, word_f};
                end
            end
            default: begin
                op.ld_result = rd.dw;  // ld passes through
            end
        endcase
    end

endmodule

/* design/ls_op_if.sv */
interface ls_op_if import lsu_pkg::*; ();

    // held operation, driven by the controller
    ls_size_t        size;
    logic            is_unsigned;
    logic [2:0]      offset;      // low address bits inside the doubleword
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] read_data;   // raw doubleword from the cache

    // aligner results
    logic [xlen-1:0] wr_data;
    logic [xlen-1:0] wr_mask;
    logic [xlen-1:0] ld_result;

    modport ctrl (
        output size, is_unsigned, offset, store_data, read_data,
        input  wr_data, wr_mask, ld_result
    );

    modport store_side (
        input  size, offset, store_data,
        output wr_data, wr_mask
    );

    modport load_side (
        input  size, is_unsigned, offset, read_data,
        output ld_result
    );

endinterface

/* design/lsu_pkg.sv */
package lsu_pkg;

    // datapath widths
    localparam int xlen        = 64;
    localparam int robid_width = 7;  // msb is the wrap bit
    localparam int preg_width  = 6;

    // access size as issued by the decoder
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2,
        size_d = 2'd3
    } ls_size_t;

    // cache bus operation
    typedef enum logic [1:0] {
        tbus_read  = 2'b00,
        tbus_write = 2'b01
    } tbus_op_t;

    // mmio window, both bounds inclusive
    localparam logic [xlen-1:0] mmio_base  = 64'h0000_0000_3000_0000;
    localparam logic [xlen-1:0] mmio_limit = 64'h0000_0000_4070_0000;

    // request fsm encoding
    localparam logic [1:0] st_idle        = 2'd0;
    localparam logic [1:0] st_request     = 2'd1;  // valid up, waiting for ready
    localparam logic [1:0] st_outstanding = 2'd2;  // transfer done, waiting for done pulse
    localparam logic [1:0] st_mmio_done   = 2'd3;

    // one doubleword seen as bytes, halves or words
    typedef union packed {
        logic [xlen-1:0]  dw;
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
    } dword_u;

endpackage

/* design/mem_req_ctrl.sv */
module mem_req_ctrl import lsu_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    // issue side
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic [xlen-1:0]        src1,
    input  logic [xlen-1:0]        src2,
    input  logic [xlen-1:0]        imm,
    input  logic [preg_width-1:0]  prd,
    input  logic [robid_width-1:0] robid,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   is_unsigned,
    input  ls_size_t               ls_size,
    // cache request bus
    output logic                   tbus_index_valid,
    input  logic                   tbus_index_ready,
    output logic [xlen-1:0]        tbus_index,
    output logic [xlen-1:0]        tbus_write_data,
    output logic [xlen-1:0]        tbus_write_mask,
    output tbus_op_t               tbus_operation_type,
    input  logic [xlen-1:0]        tbus_read_data,
    input  logic                   tbus_operation_done,
    // writeback
    output logic                   out_valid,
    output logic [robid_width-1:0] out_robid,
    output logic [preg_width-1:0]  out_prd,
    output logic                   out_need_wb,
    output logic [xlen-1:0]        out_rddata,
    // redirect
    input  logic                   flush_valid,
    input  logic [robid_width-1:0] flush_robid,
    output logic                   mem_flush,
    // aligners
    ls_op_if.ctrl                  op
);

    localparam int rmsb = robid_width - 1;

    logic [1:0]             state_q;
    logic [1:0]             state_d;
    logic [xlen-1:0]        ls_addr;
    logic                   in_mmio;
    logic                   accept;
    logic                   need_flush;
    logic                   op_done;

    // held operation
    logic [xlen-1:0]        addr_q;
    logic [xlen-1:0]        src2_q;
    ls_size_t               size_q;
    logic                   unsigned_q;
    logic                   store_q;
    logic [robid_width-1:0] robid_q;
    logic [preg_width-1:0]  prd_q;
    logic                   need_wb_q;
    logic                   killed_q;  // flushed earlier, finish on the bus silently

    assign ls_addr = src1 + imm;
    assign in_mmio = (ls_addr >= mmio_base) && (ls_addr <= mmio_limit);

    assign instr_ready = (state_q == st_idle);
    assign accept      = instr_valid & instr_ready;

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q     <= ls_addr;
            src2_q     <= src2;
            size_q     <= ls_size;
            unsigned_q <= is_unsigned;
            store_q    <= is_store;
            robid_q    <= robid;
            prd_q      <= prd;
        end
    end

    // older flush: wrap bits differ xor flush index below ours
    assign need_flush = flush_valid && (state_q != st_idle) &&
                        ((flush_robid[rmsb] ^ robid_q[rmsb]) ^
                         (flush_robid[rmsb-1:0] < robid_q[rmsb-1:0]));
    assign mem_flush  = need_flush;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = in_mmio ? st_mmio_done : st_request;
                end
            end
            st_request: begin
                if (tbus_index_ready) begin
                    state_d = st_outstanding;
                end
            end
            st_outstanding: begin
                if (tbus_operation_done) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;  // mmio completes in one cycle
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= st_idle;
            need_wb_q <= 1'b0;
            killed_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                need_wb_q <= is_load;
                killed_q  <= 1'b0;
            end else if (need_flush) begin
                killed_q <= 1'b1;
            end
        end
    end

    // feed the aligners from the held operation
    assign op.size        = size_q;
    assign op.is_unsigned = unsigned_q;
    assign op.offset      = addr_q[2:0];
    assign op.store_data  = src2_q;
    assign op.read_data   = tbus_read_data;

    assign tbus_index_valid    = (state_q == st_request);
    assign tbus_index          = addr_q;
    assign tbus_write_data     = op.wr_data;
    assign tbus_write_mask     = store_q ? op.wr_mask : '0;  // reads touch no lanes
    assign tbus_operation_type = store_q ? tbus_write : tbus_read;

    assign op_done = ((state_q == st_outstanding) & tbus_operation_done) |
                     (state_q == st_mmio_done);

    assign out_valid   = op_done & ~need_flush & ~killed_q;
    assign out_robid   = robid_q;
    assign out_prd     = prd_q;
    assign out_need_wb = need_wb_q;
    assign out_rddata  = (state_q == st_outstanding) ? op.ld_result : '0; // mmio reads zero

endmodule

/* design/mem_unit.sv */
module mem_unit import lsu_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic [xlen-1:0]        src1,
    input  logic [xlen-1:0]        src2,
    input  logic [xlen-1:0]        imm,
    input  logic [preg_width-1:0]  prd,
    input  logic [robid_width-1:0] robid,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   is_unsigned,
    input  ls_size_t               ls_size,
    output logic                   tbus_index_valid,
    input  logic                   tbus_index_ready,
    output logic [xlen-1:0]        tbus_index,
    output logic [xlen-1:0]        tbus_write_data,
    output logic [xlen-1:0]        tbus_write_mask,
    output tbus_op_t               tbus_operation_type,
    input  logic [xlen-1:0]        tbus_read_data,
    input  logic                   tbus_operation_done,
    output logic                   out_valid,
    output logic [robid_width-1:0] out_robid,
    output logic [preg_width-1:0]  out_prd,
    output logic                   out_need_wb,
    output logic [xlen-1:0]        out_rddata,
    input  logic                   flush_valid,
    input  logic [robid_width-1:0] flush_robid,
    output logic                   mem_flush
);

    ls_op_if u_if ();  // held op out, aligned data back

    mem_req_ctrl u_ctrl (
        .clock               (clock),
        .reset_n             (reset_n),
        .instr_valid         (instr_valid),
        .instr_ready         (instr_ready),
        .src1                (src1),
        .src2                (src2),
        .imm                 (imm),
        .prd                 (prd),
        .robid               (robid),
        .is_load             (is_load),
        .is_store            (is_store),
        .is_unsigned         (is_unsigned),
        .ls_size             (ls_size),
        .tbus_index_valid    (tbus_index_valid),
        .tbus_index_ready    (tbus_index_ready),
        .tbus_index          (tbus_index),
        .tbus_write_data     (tbus_write_data),
        .tbus_write_mask     (tbus_write_mask),
        .tbus_operation_type (tbus_operation_type),
        .tbus_read_data      (tbus_read_data),
        .tbus_operation_done (tbus_operation_done),
        .out_valid           (out_valid),
        .out_robid           (out_robid),
        .out_prd             (out_prd),
        .out_need_wb         (out_need_wb),
        .out_rddata          (out_rddata),
        .flush_valid         (flush_valid),
        .flush_robid         (flush_robid),
        .mem_flush           (mem_flush),
        .op                  (u_if.ctrl)
    );

    // both aligners look at the same held operation
    store_align u_store (
        .op (u_if.store_side)
    );

    load_align u_load (
        .op (u_if.load_side)
    );

endmodule

/* design/store_align.sv */
module store_align import lsu_pkg::*; (
    ls_op_if.store_side op
);

    logic [xlen-1:0] base_mask;
    logic [5:0]      bit_shift;

    assign bit_shift = {op.offset, 3'b000};  // byte offset times eight

    // unshifted mask covering the access width
    always_comb begin
        unique case (op.size)
            size_b: begin
                base_mask = 64'h0000_0000_0000_00ff;
            end
            size_h: begin
                base_mask = 64'h0000_0000_0000_ffff;
            end
            size_w: begin
                base_mask = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                base_mask = '1;
            end
        endcase
    end

    // data moves to the lane the address points at
    assign op.wr_data = op.store_data << bit_shift;

    // doubleword always writes every lane
    always_comb begin
        if (op.size == size_d) begin
            op.wr_mask = '1;
        end else begin
            op.wr_mask = base_mask << bit_shift;
        end
    end

endmodule

/* dv/tb_mem_unit.sv */
module tb_mem_unit import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 64;  // cycles any single wait may take
    localparam logic [xlen-1:0] mem_base = 64'h0000_0000_8000_0000;

    logic                   clock;
    logic                   reset_n;
    logic                   instr_valid;
    logic                   instr_ready;
    logic [xlen-1:0]        src1;
    logic [xlen-1:0]        src2;
    logic [xlen-1:0]        imm;
    logic [preg_width-1:0]  prd;
    logic [robid_width-1:0] robid;
    logic                   is_load;
    logic                   is_store;
    logic                   is_unsigned;
    ls_size_t               ls_size;
    logic                   tbus_index_valid;
    logic                   tbus_index_ready;
    logic [xlen-1:0]        tbus_index;
    logic [xlen-1:0]        tbus_write_data;
    logic [xlen-1:0]        tbus_write_mask;
    tbus_op_t               tbus_operation_type;
    logic [xlen-1:0]        tbus_read_data;
    logic                   tbus_operation_done;
    logic                   out_valid;
    logic [robid_width-1:0] out_robid;
    logic [preg_width-1:0]  out_prd;
    logic                   out_need_wb;
    logic [xlen-1:0]        out_rddata;
    logic                   flush_valid;
    logic [robid_width-1:0] flush_robid;
    logic                   mem_flush;

    logic [xlen-1:0]        shadow [256];  // reference copy of cache contents
    logic [robid_width-1:0] held_robid;
    logic [xlen-1:0]        issue_addr;
    int                     errors;
    int                     timeouts;
    int                     checks;

    mem_unit u_dut (.*);
    tbus_mem_model u_mem (.*);

    always #50 clock = ~clock;

    assign issue_addr = src1 + imm;

    // rob ids live on a circular buffer, the top bit flips on wrap
    function automatic logic is_older(logic [robid_width-1:0] f, logic [robid_width-1:0] h);
        if (f[robid_width-1] == h[robid_width-1]) begin
            return f[robid_width-2:0] < h[robid_width-2:0];
        end
        return f[robid_width-2:0] >= h[robid_width-2:0];
    endfunction

    function automatic logic [xlen-1:0] expect_load(logic [xlen-1:0] dw, ls_size_t sz,
                                                    logic [2:0] off, logic uns);
        logic [xlen-1:0] v;
        int              nbits;
        nbits = 8 << sz;
        v = dw >> (8 * off);
        if (nbits < xlen) begin
            v = v & ((64'd1 << nbits) - 64'd1);
            if (!uns && v[nbits-1]) begin
                v = v | ~((64'd1 << nbits) - 64'd1);  // sign fill
            end
        end
        return v;
    endfunction

    function automatic logic [xlen-1:0] expect_mask(ls_size_t sz, logic [2:0] off);
        logic [xlen-1:0] m;
        m = '0;
        for (int b = 0; b < (1 << sz); b++) begin
            m[8*(off+b) +: 8] = 8'hff;
        end
        return m;
    endfunction

    task automatic compare_value(string name, logic [xlen-1:0] got, logic [xlen-1:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic report_timeout(string what);
        timeouts++;
        $display("timeout: no %s within %0d cycles at %0t", what, wait_limit, $time);
    endtask

    a_hold: assert property (@(posedge clock) disable iff (!reset_n)
        tbus_index_valid && !tbus_index_ready |=> tbus_index_valid
            && $stable(tbus_index) && $stable(tbus_write_data)
            && $stable(tbus_write_mask) && $stable(tbus_operation_type))
        else begin
            errors++;
            $display("request dropped or changed before ready at %0t", $time);
        end

    a_busy: assert property (@(posedge clock) disable iff (!reset_n)
        tbus_index_valid || out_valid |-> !instr_ready)
        else begin
            errors++;
            $display("instr_ready high while an operation is held at %0t", $time);
        end

    // an older flush in the completion cycle takes the writeback away
    a_mmio: assert property (@(posedge clock) disable iff (!reset_n)
        instr_valid && instr_ready && issue_addr >= mmio_base && issue_addr <= mmio_limit
            |=> out_valid == !(flush_valid && is_older(flush_robid, held_robid))
                && !tbus_index_valid && out_rddata == '0)
        else begin
            errors++;
            $display("mmio access did not finish one cycle after acceptance at %0t", $time);
        end

    a_flush: assert property (@(posedge clock) disable iff (!reset_n)
        flush_valid && !instr_ready |-> mem_flush == is_older(flush_robid, held_robid))
        else begin
            errors++;
            $display("[FAIL] mem_flush: got %h, expected %h", $sampled(mem_flush),
                     is_older($sampled(flush_robid), $sampled(held_robid)));
        end

    a_quiet: assert property (@(posedge clock) disable iff (!reset_n)
        mem_flush |-> !out_valid)
        else begin
            errors++;
            $display("writeback raised in a flush cycle at %0t", $time);
        end

    // issue one operation, optionally flush it, and wait until the unit is idle again
    task automatic run_op(input logic ld, input ls_size_t sz, input logic uns,
                          input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                          input logic [robid_width-1:0] rid, input logic flush,
                          input logic [robid_width-1:0] frid);
        logic [7:0]      slot;
        logic            mmio;
        logic            seen;
        logic [xlen-1:0] want;
        logic [xlen-1:0] mask;
        int              n;
        slot = addr[10:3];
        mmio = (addr >= mmio_base) && (addr <= mmio_limit);
        mask = expect_mask(sz, addr[2:0]);
        want = mmio ? '0 : expect_load(shadow[slot], sz, addr[2:0], uns);
        seen = 1'b0;
        @(posedge clock);
        #5;
        instr_valid = 1'b1;
        src1        = addr + 64'h40;
        imm         = -64'h40;  // base plus negative offset
        src2        = data;
        robid       = rid;
        prd         = rid[5:0] ^ 6'h15;
        is_load     = ld;
        is_store    = !ld;
        is_unsigned = uns;
        ls_size     = sz;
        held_robid  = rid;
        for (n = 0; n < wait_limit && !instr_ready; n++) begin
            @(negedge clock);
        end
        if (!instr_ready) begin
            report_timeout("instr_ready");
        end
        @(posedge clock);
        #5;
        instr_valid = 1'b0;
        flush_valid = flush;
        flush_robid = frid;
        for (n = 0; n < wait_limit; n++) begin
            @(negedge clock);
            if (tbus_index_valid) begin
                compare_value("tbus_index", tbus_index, addr);
                compare_value("tbus_operation_type", 64'(tbus_operation_type),
                              ld ? 64'(tbus_read) : 64'(tbus_write));
                if (!ld) begin
                    compare_value("tbus_write_mask", tbus_write_mask, mask);
                    compare_value("tbus_write_data", tbus_write_data, data << (8 * addr[2:0]));
                end
            end
            if (out_valid) begin
                seen = 1'b1;
                compare_value("out_robid", 64'(out_robid), 64'(rid));
                compare_value("out_prd", 64'(out_prd), 64'(rid[5:0] ^ 6'h15));
                compare_value("out_need_wb", 64'(out_need_wb), 64'(ld));
                if (ld) begin
                    compare_value("out_rddata", out_rddata, want);
                end
            end
            if (instr_ready) begin
                break;
            end
            @(posedge clock);
            #5;
            flush_valid = 1'b0;
        end
        if (!instr_ready) begin
            report_timeout("completion");
        end
        compare_value("out_valid seen", 64'(seen), 64'(!(flush && is_older(frid, rid))));
        if (!ld && !mmio) begin
            // a flushed store still reaches memory
            shadow[slot] = (shadow[slot] & ~mask) | ((data << (8 * addr[2:0])) & mask);
        end
    endtask

    initial begin
        logic [robid_width-1:0] rid;
        logic [xlen-1:0]        addr;
        int                     slot;
        clock       = 1'b0;
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        src1        = '0;
        src2        = '0;
        imm         = '0;
        prd         = '0;
        robid       = '0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        ls_size     = size_b;
        flush_valid = 1'b0;
        flush_robid = '0;
        held_robid  = '0;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        repeat (4) @(posedge clock);
        #5;
        reset_n = 1'b1;
        @(negedge clock);
        compare_value("instr_ready", 64'(instr_ready), 64'd1);
        compare_value("tbus_index_valid", 64'(tbus_index_valid), 64'd0);
        compare_value("out_valid", 64'(out_valid), 64'd0);
        compare_value("mem_flush", 64'(mem_flush), 64'd0);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = u_mem.mem[i];
        end

        rid = '0;
        for (int s = 0; s < 4; s++) begin  // loads, every size, sign and offset
            for (int u = 0; u < 2; u++) begin
                for (int o = 0; o < 8; o += (1 << s)) begin
                    slot = s * 32 + u * 8 + o;
                    addr = mem_base + 64'(slot * 8 + o);
                    run_op(1'b1, ls_size_t'(s), u[0], addr, '0, rid, 1'b0, '0);
                    rid = rid + 7'd1;
                end
            end
        end

        for (int s = 0; s < 4; s++) begin  // store then read the merged doubleword
            for (int o = 0; o < 8; o += (1 << s)) begin
                slot = 128 + s * 8 + o;
                addr = mem_base + 64'(slot * 8);
                run_op(1'b0, ls_size_t'(s), 1'b0, addr + 64'(o),
                       64'h8899_aabb_ccdd_eeff ^ 64'(slot), rid, 1'b0, '0);
                run_op(1'b1, size_d, 1'b0, addr, '0, rid + 7'd1, 1'b0, '0);
                rid = rid + 7'd2;
            end
        end

        run_op(1'b1, size_w, 1'b0, mmio_base + 64'h8, '0, 7'h21, 1'b0, '0);
        run_op(1'b0, size_d, 1'b0, mmio_limit, 64'h1234_5678, 7'h22, 1'b0, '0);
        run_op(1'b1, size_b, 1'b0, mmio_limit, '0, 7'h23, 1'b0, '0);
        run_op(1'b1, size_d, 1'b0, mmio_base - 64'h8, '0, 7'h24, 1'b0, '0);  // just outside
        run_op(1'b1, size_d, 1'b0, mmio_limit + 64'h8, '0, 7'h25, 1'b0, '0);
        run_op(1'b1, size_w, 1'b0, mmio_base + 64'h10, '0, 7'h26, 1'b1, 7'h1f);  // flush on done

        addr = mem_base + 64'h50;
        run_op(1'b1, size_d, 1'b0, addr, '0, 7'h10, 1'b1, 7'h08);  // older, same lap
        run_op(1'b1, size_d, 1'b0, addr, '0, 7'h05, 1'b1, 7'h50);  // older, across wrap
        run_op(1'b1, size_d, 1'b0, addr, '0, 7'h10, 1'b1, 7'h20);  // younger
        run_op(1'b1, size_d, 1'b0, addr, '0, 7'h50, 1'b1, 7'h05);  // younger, across wrap
        run_op(1'b0, size_w, 1'b0, addr + 64'h4, 64'hdead_beef, 7'h12, 1'b1, 7'h02);
        run_op(1'b1, size_d, 1'b0, addr, '0, 7'h13, 1'b0, '0);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* dv/tbus_mem_model.sv */
module tbus_mem_model import lsu_pkg::*; (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            tbus_index_valid,
    output logic            tbus_index_ready,
    input  logic [xlen-1:0] tbus_index,
    input  logic [xlen-1:0] tbus_write_data,
    input  logic [xlen-1:0] tbus_write_mask,
    input  tbus_op_t        tbus_operation_type,
    output logic [xlen-1:0] tbus_read_data,
    output logic            tbus_operation_done
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth     = 256;  // doublewords
    localparam int done_lat  = 2;
    localparam int stall_pct = 35;   // chance of ready low in a cycle

    logic [xlen-1:0] mem [depth];

    // each byte of the fill is built from the full slot number
    function automatic logic [xlen-1:0] fill_word(logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'h31,
                {a[3:0], a[7:4]}, a ^ 8'hc3, ~(a + 8'h17), a - 8'h6e};
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = fill_word(i[7:0]);
        end
    end

    initial begin
        logic            xfer;
        logic            is_write;
        logic [7:0]      slot;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] wmask;
        int              pend;
        void'($urandom(32'ha01c));
        tbus_index_ready    = 1'b0;
        tbus_operation_done = 1'b0;
        tbus_read_data      = '0;
        pend                = 0;
        slot                = '0;
        forever begin
            @(negedge clock);
            xfer = reset_n && tbus_index_valid && tbus_index_ready;  // transfer on next edge
            if (xfer) begin
                slot     = tbus_index[10:3];
                wdata    = tbus_write_data;
                wmask    = tbus_write_mask;
                is_write = (tbus_operation_type == tbus_write);
            end
            @(posedge clock);
            #5;
            tbus_operation_done = 1'b0;
            if (pend > 0) begin
                pend--;
                if (pend == 0) begin
                    tbus_operation_done = 1'b1;
                    tbus_read_data      = mem[slot];
                end
            end
            if (xfer) begin
                if (is_write) begin
                    mem[slot] = (mem[slot] & ~wmask) | (wdata & wmask);  // bit-level mask
                end
                pend = done_lat;
            end
            tbus_index_ready = reset_n && (($urandom % 100) >= stall_pct);
        end
    end

endmodule

/* sources.f */
design/lsu_pkg.sv
design/ls_op_if.sv
design/store_align.sv
design/load_align.sv
design/mem_req_ctrl.sv
design/mem_unit.sv
dv/tbus_mem_model.sv
dv/tb_mem_unit.sv
